// File: logic/core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// processor-wide definitions for the two-wide in-order core
// address and instruction words, fetch width and the PC after reset
// imported by every fetch front end block and by the testbench
////////////////////////////////////////////////////////////////////////////

package core_pkg;

  localparam int ADDR_WIDTH = 64;              // virtual address width
  localparam int INST_WIDTH = 32;              // fixed-size instruction word

  typedef logic [ADDR_WIDTH-1:0] addr_t;       // instruction address
  typedef logic [INST_WIDTH-1:0] inst_t;       // one raw instruction

  // superscalar width of the fetch path
  localparam int NUM_SUPER  = 2;               // instructions per fetch
  localparam int INST_BYTES = INST_WIDTH / 8;  // 4 bytes per instruction

  // first fetch after reset comes from here
  localparam addr_t RESET_PC = '0;

endpackage

// File: logic/imem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// instruction memory definitions shared by memory, fetch and testbench
// one line carries a full fetch group of NUM_SUPER instructions
////////////////////////////////////////////////////////////////////////////

package imem_pkg;

  // line holds slot 0 in the low half, slot 1 in the high half
  typedef logic [core_pkg::NUM_SUPER*$bits(core_pkg::inst_t)-1:0] line_t;

  localparam int LINE_BYTES  = core_pkg::NUM_SUPER * core_pkg::INST_BYTES; // 8
  localparam int LINE_OFFSET = $clog2(LINE_BYTES);  // byte offset bits in an address

  // defaults, normally overridden from the top level
  localparam int DEFAULT_MEM_LINES   = 64;          // depth in lines
  localparam int DEFAULT_MEM_LATENCY = 2;           // cycles to answer a new address

endpackage

// File: logic/inst_mem.sv
////////////////////////////////////////////////////////////////////////////
// on-chip instruction RAM with a loader write port
// a fetch address is answered MEM_LATENCY cycles after it is captured
// the array has no reset so it can be filled while the core is in reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module inst_mem #(
  parameter int MEM_LINES   = imem_pkg::DEFAULT_MEM_LINES,   // power of two
  parameter int MEM_LATENCY = imem_pkg::DEFAULT_MEM_LATENCY  // at least 1
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         load_en,      // one line per edge while high
  input  logic [$clog2(MEM_LINES)-1:0] load_index,   // line being written
  input  imem_pkg::line_t              load_line,
  input  core_pkg::addr_t              imem_addr,    // line aligned fetch address
  output imem_pkg::line_t              imem_line,    // registered read data
  output logic                         imem_valid    // level, line matches imem_addr
);
  import core_pkg::*;
  import imem_pkg::*;

  localparam int IDX_W = $clog2(MEM_LINES);
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  line_t            mem [MEM_LINES];   // instruction lines
  addr_t            addr_q;            // last captured fetch address
  logic [CNT_W-1:0] wait_cnt;          // edges since capture, saturates
  logic [IDX_W-1:0] rd_index;
  logic             addr_new;          // fetch side moved to another line

  // address / LINE_BYTES, wrapped to the array depth
  assign rd_index = imem_addr[LINE_OFFSET +: IDX_W];
  assign addr_new = (imem_addr != addr_q);

  ////////////////////////////////////////////////////////////////////////////
  // array write and read
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (load_en)
      mem[load_index] <= load_line;    // loader write, also active in reset
    imem_line <= mem[rd_index];        // follows the presented address
  end

  ////////////////////////////////////////////////////////////////////////////
  // latency tracking
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      addr_q   <= '1;                  // unaligned, forces a first capture
      wait_cnt <= '0;
    end
    else if (addr_new)
    begin
      addr_q   <= imem_addr;           // capture, restart the wait
      wait_cnt <= '0;
    end
    else if (wait_cnt != CNT_W'(MEM_LATENCY))
      wait_cnt <= wait_cnt + 1'b1;
  end

  // a stale line is never offered once the address has moved on
  assign imem_valid = (wait_cnt == CNT_W'(MEM_LATENCY)) && !addr_new;

endmodule

// File: logic/fetch_stage.sv
////////////////////////////////////////////////////////////////////////////
// fetch stage of the two-wide front end
// holds the PC, picks the next PC and splits the returned line into slots
// if_fire marks the cycle a fetched pair is handed to the fetch queue
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_stage (
  input  logic            clock,
  input  logic            reset,
  input  logic            get_next_inst,   // queue has room
  input  logic            take_branch,     // one-cycle redirect from the back end
  input  core_pkg::addr_t branch_target,   // 8-byte aligned
  input  imem_pkg::line_t imem_line,
  input  logic            imem_valid,
  output core_pkg::addr_t imem_addr,
  output logic            if_fire,         // pair accepted this cycle
  output core_pkg::addr_t if_pc0,
  output core_pkg::addr_t if_pc1,
  output core_pkg::addr_t if_npc0,
  output core_pkg::addr_t if_npc1,
  output core_pkg::inst_t if_ir0,
  output core_pkg::inst_t if_ir1
);
  import core_pkg::*;
  import imem_pkg::*;

  addr_t pc_reg;        // address of the pair being fetched
  addr_t pc_plus_8;     // sequential successor
  addr_t next_pc;
  logic  pc_enable;

  // memory works on whole lines
  assign imem_addr = pc_reg & ~addr_t'(LINE_BYTES - 1);

  // a redirect in the same cycle kills the pair from the old path
  assign if_fire = imem_valid && get_next_inst && !take_branch;

  ////////////////////////////////////////////////////////////////////////////
  // next PC
  ////////////////////////////////////////////////////////////////////////////
  assign pc_plus_8 = pc_reg + addr_t'(LINE_BYTES);
  assign next_pc   = take_branch ? branch_target : pc_plus_8;

  // branch loads even when the queue is full, else it would be dropped
  assign pc_enable = if_fire || take_branch;

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_reg <= RESET_PC;
    else if (pc_enable)
      pc_reg <= next_pc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot split
  ////////////////////////////////////////////////////////////////////////////
  assign if_pc0  = pc_reg;                            // low half of the line
  assign if_npc0 = pc_reg + addr_t'(INST_BYTES);
  assign if_pc1  = pc_reg + addr_t'(INST_BYTES);      // high half
  assign if_npc1 = pc_plus_8;

  assign if_ir0 = imem_line[0 +: $bits(inst_t)];
  assign if_ir1 = imem_line[$bits(inst_t) +: $bits(inst_t)];

endmodule

// File: logic/fetch_queue.sv
////////////////////////////////////////////////////////////////////////////
// fetch queue between fetch and decode
// circular buffer of fetched pairs, flushed by a taken branch
// not_full throttles fetch, out_valid tells decode a pair is waiting
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_queue #(
  parameter int QUEUE_DEPTH = 4             // entries, power of two
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            flush,            // drop everything queued
  input  logic            push,             // write one pair, room already checked
  input  core_pkg::addr_t pc0,
  input  core_pkg::addr_t pc1,
  input  core_pkg::addr_t npc0,
  input  core_pkg::addr_t npc1,
  input  core_pkg::inst_t ir0,
  input  core_pkg::inst_t ir1,
  input  logic            pop,              // ignored while empty
  output logic            not_full,
  output logic            out_valid,
  output core_pkg::addr_t out_pc0,
  output core_pkg::addr_t out_pc1,
  output core_pkg::addr_t out_npc0,
  output core_pkg::addr_t out_npc1,
  output core_pkg::inst_t out_ir0,
  output core_pkg::inst_t out_ir1
);
  import core_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  // one fetched pair
  typedef struct packed {
    addr_t pc0;
    addr_t pc1;
    addr_t npc0;
    addr_t npc1;
    inst_t ir0;
    inst_t ir1;
  } entry_t;

  entry_t           q_mem [QUEUE_DEPTH];    // payload storage
  entry_t           head;                   // oldest entry
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;                  // occupancy, 0 .. QUEUE_DEPTH
  logic             do_pop;

  assign do_pop    = pop && out_valid;
  assign not_full  = (count != (PTR_W+1)'(QUEUE_DEPTH));
  assign out_valid = (count != '0);

  // payload write
  always_ff @(posedge clock)
  begin
    if (push)
      q_mem[wr_ptr] <= '{pc0: pc0, pc1: pc1, npc0: npc0, npc1: npc1, ir0: ir0, ir1: ir1};
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset || flush)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;            // wraps on power-of-two depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !push)
        count <= count - 1'b1;
    end
  end

  // head of the queue straight to decode
  assign head     = q_mem[rd_ptr];
  assign out_pc0  = head.pc0;
  assign out_pc1  = head.pc1;
  assign out_npc0 = head.npc0;
  assign out_npc1 = head.npc1;
  assign out_ir0  = head.ir0;
  assign out_ir1  = head.ir1;

endmodule

// File: logic/fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// fetch front end top level
// ties the instruction RAM, fetch stage and fetch queue together
// memory depth, memory latency and queue depth are chosen here
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_top #(
  parameter int MEM_LINES   = imem_pkg::DEFAULT_MEM_LINES,
  parameter int MEM_LATENCY = imem_pkg::DEFAULT_MEM_LATENCY,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         load_en,        // loader write strobe
  input  logic [$clog2(MEM_LINES)-1:0] load_index,
  input  imem_pkg::line_t              load_line,
  input  logic                         take_branch,    // redirect and flush
  input  core_pkg::addr_t              branch_target,
  input  logic                         deq,            // decode pops a pair
  output logic                         out_valid,
  output core_pkg::addr_t              out_pc0,
  output core_pkg::addr_t              out_pc1,
  output core_pkg::addr_t              out_npc0,
  output core_pkg::addr_t              out_npc1,
  output core_pkg::inst_t              out_ir0,
  output core_pkg::inst_t              out_ir1
);
  import core_pkg::*;
  import imem_pkg::*;

  addr_t imem_addr;                        // fetch to memory
  line_t imem_line;                        // memory to fetch
  logic  imem_valid;
  logic  get_next_inst;                    // queue has room
  logic  if_fire;                          // pair handed to the queue
  addr_t if_pc0, if_pc1, if_npc0, if_npc1;
  inst_t if_ir0, if_ir1;

  inst_mem #(.MEM_LINES(MEM_LINES), .MEM_LATENCY(MEM_LATENCY)) imem (
    .clock, .reset,
    .load_en, .load_index, .load_line,
    .imem_addr, .imem_line, .imem_valid
  );

  fetch_stage fetch (
    .clock, .reset,
    .get_next_inst, .take_branch, .branch_target,
    .imem_line, .imem_valid, .imem_addr,
    .if_fire, .if_pc0, .if_pc1, .if_npc0, .if_npc1, .if_ir0, .if_ir1
  );

  // taken branch empties the queue in the cycle it redirects fetch
  fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue (
    .clock, .reset,
    .flush(take_branch), .push(if_fire),
    .pc0(if_pc0), .pc1(if_pc1), .npc0(if_npc0), .npc1(if_npc1),
    .ir0(if_ir0), .ir1(if_ir1),
    .pop(deq), .not_full(get_next_inst),
    .out_valid, .out_pc0, .out_pc1, .out_npc0, .out_npc1, .out_ir0, .out_ir1
  );

endmodule

// File: sim/clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// testbench clock and reset source
// free running clock, reset held for a number of rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module clock_gen #(
  parameter real PERIOD       = 8.0,   // ns
  parameter int  RESET_CYCLES = 16     // rising edges with reset high
) (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #(PERIOD / 2.0) clock = ~clock;
  end

  initial
  begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);                  // release away from the active edge
    reset = 1'b0;
  end

endmodule

// File: sim/fetch_chk.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the fetch front end, bound into the top level
// covers queue output PC relations, flush, redirect, stall and reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_chk (
  input logic            clock,
  input logic            reset,
  input logic            take_branch,
  input core_pkg::addr_t branch_target,
  input logic            out_valid,
  input core_pkg::addr_t out_pc0,
  input core_pkg::addr_t out_pc1,
  input core_pkg::addr_t out_npc0,
  input core_pkg::addr_t out_npc1,
  input core_pkg::addr_t imem_addr,
  input logic            imem_valid,
  input logic            if_fire,
  input logic            get_next_inst
);
  import core_pkg::*;

  int fail_count = 0;                  // failed checks, read at the end of the run

  // slot 1 and both next PCs follow from slot 0
  a_pc_pair: assert property (@(posedge clock) disable iff (reset)
    out_valid |-> (out_pc1 == out_pc0 + 64'd4) && (out_npc0 == out_pc0 + 64'd4)
                  && (out_npc1 == out_pc0 + 64'd8))
    else begin fail_count++; $error("queue head PCs are inconsistent"); end

  // reset leaves everything idle and the PC at its start value
  a_reset: assert property (@(posedge clock)
    reset |=> !out_valid && !imem_valid && !if_fire && get_next_inst
              && (imem_addr == RESET_PC))
    else begin fail_count++; $error("front end not idle after reset"); end

  // taken branch empties the queue
  a_flush: assert property (@(posedge clock) disable iff (reset)
    take_branch |=> !out_valid)
    else begin fail_count++; $error("queue not flushed by branch"); end

  // redirect is honored even when fetch is stalled
  a_redirect: assert property (@(posedge clock) disable iff (reset)
    take_branch |=> (imem_addr == $past(branch_target)))
    else begin fail_count++; $error("fetch did not move to branch target"); end

  // full queue holds the fetch address
  a_hold: assert property (@(posedge clock) disable iff (reset)
    (!get_next_inst && !take_branch) |=> $stable(imem_addr))
    else begin fail_count++; $error("fetch moved on while queue full"); end

endmodule

bind fetch_top fetch_chk chk (
  .clock(clock), .reset(reset),
  .take_branch(take_branch), .branch_target(branch_target),
  .out_valid(out_valid), .out_pc0(out_pc0), .out_pc1(out_pc1),
  .out_npc0(out_npc0), .out_npc1(out_npc1),
  .imem_addr(imem_addr), .imem_valid(imem_valid),
  .if_fire(if_fire), .get_next_inst(get_next_inst)
);

// File: sim/fetch_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the fetch front end
// loads the RAM during reset, then runs sequential fetch, back-pressure
// and branch phases against a shadow PC and a shadow copy of the RAM
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_tb;
  import core_pkg::*;
  import imem_pkg::*;

  localparam int  MEM_LINES   = 16;
  localparam int  MEM_LATENCY = 2;
  localparam int  QUEUE_DEPTH = 4;
  localparam int  IDX_W       = $clog2(MEM_LINES);
  localparam int  TEST_CYCLES = 400;   // upper bound for all phases
  localparam real TIMEOUT_NS  = (MEM_LINES + TEST_CYCLES) * 8.0 * 2.0;

  logic             clock, reset;
  logic             load_en;
  logic [IDX_W-1:0] load_index;
  line_t            load_line;
  logic             take_branch;
  addr_t            branch_target;
  logic             deq;
  logic             out_valid;
  addr_t            out_pc0, out_pc1, out_npc0, out_npc1;
  inst_t            out_ir0, out_ir1;

  line_t  shadow [MEM_LINES];          // what the loader wrote
  addr_t  exp_pc;                      // pc0 of the next pair decode should get
  addr_t  target;
  integer seed   = 91234;
  int     errors = 0;
  int     pops   = 0;

  clock_gen #(.PERIOD(8.0), .RESET_CYCLES(16)) clk_rst (.clock, .reset);

  fetch_top #(
    .MEM_LINES(MEM_LINES), .MEM_LATENCY(MEM_LATENCY), .QUEUE_DEPTH(QUEUE_DEPTH)
  ) UUT (
    .clock, .reset, .load_en, .load_index, .load_line,
    .take_branch, .branch_target, .deq,
    .out_valid, .out_pc0, .out_pc1, .out_npc0, .out_npc1, .out_ir0, .out_ir1
  );

  // RAM line holding a given PC with the array wrapping around
  function automatic int line_index(input addr_t pc);
    return int'((pc >> 3) % 64'(MEM_LINES));
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch %s: expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  // head of the queue against the shadow model
  task automatic check_pair();
    line_t line;
    line = shadow[line_index(exp_pc)];
    check_value("out_pc0", exp_pc, out_pc0);
    check_value("out_pc1", exp_pc + 64'd4, out_pc1);
    check_value("out_npc0", exp_pc + 64'd4, out_npc0);
    check_value("out_npc1", exp_pc + 64'd8, out_npc1);
    check_value("out_ir0", 64'(line[31:0]), 64'(out_ir0));   // low half is slot 0
    check_value("out_ir1", 64'(line[63:32]), 64'(out_ir1));
  endtask

  // one cycle of stimulus driven on the falling edge
  task automatic run_cycle(input logic pop_req, input logic branch, input addr_t tgt);
    @(negedge clock);
    deq           = pop_req;
    take_branch   = branch;
    branch_target = tgt;
    if (branch)
      exp_pc = tgt;                    // anything still queued is dropped
    else if (pop_req && out_valid)
    begin
      check_pair();                    // this pair leaves at the next edge
      exp_pc = exp_pc + 64'd8;
      pops++;
    end
  endtask

  task automatic expect_full(input string where);
    if (UUT.get_next_inst !== 1'b0)
    begin
      errors++;
      $display("queue did not fill %s at %0t", where, $time);
    end
  endtask

  initial
  begin
    load_en       = 1'b0;
    load_index    = '0;
    load_line     = '0;
    take_branch   = 1'b0;
    branch_target = '0;
    deq           = 1'b0;
    exp_pc        = RESET_PC;

    // fill the RAM while the core sits in reset
    for (int i = 0; i < MEM_LINES; i++)
    begin
      @(negedge clock);
      if (i > 0 && out_valid !== 1'b0)
      begin
        errors++;
        $display("out_valid high during reset at %0t", $time);
      end
      load_en    = 1'b1;
      load_index = IDX_W'(i);
      load_line  = {$random(seed), $random(seed)};
      shadow[i]  = load_line;
    end
    @(negedge clock);                  // first cycle out of reset
    load_en = 1'b0;
    wait (!reset);
    if (out_valid !== 1'b0)
    begin
      errors++;
      $display("out_valid high right after reset release at %0t", $time);
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequential fetch with random pop gaps
    ////////////////////////////////////////////////////////////////////////////
    repeat (60) run_cycle(($random(seed) & 3) != 0, 1'b0, '0);

    // long hold then a drain that must continue the sequence
    repeat (20) run_cycle(1'b0, 1'b0, '0);
    expect_full("under back-pressure");
    repeat (12) run_cycle(1'b1, 1'b0, '0);

    ////////////////////////////////////////////////////////////////////////////
    // taken branches with every other one issued while the queue is full
    ////////////////////////////////////////////////////////////////////////////
    for (int k = 0; k < 6; k++)
    begin
      if (k % 2 == 0)
      begin
        repeat (20) run_cycle(1'b0, 1'b0, '0);
        expect_full("before stalled branch");
      end
      else
        repeat (3) run_cycle(1'b1, 1'b0, '0);
      target = addr_t'(($random(seed) & 63) * 8);   // aligned and possibly past the RAM
      run_cycle(1'b0, 1'b1, target);
      repeat (12) run_cycle(1'b1, 1'b0, '0);
    end

    repeat (2) run_cycle(1'b0, 1'b0, '0);  // let pending assertions finish
    if (pops == 0)
    begin
      errors++;
      $display("no pair was ever popped from the queue");
    end
    $display("value errors %0d, assertion errors %0d, pairs popped %0d",
             errors, UUT.chk.fail_count, pops);
    if (errors == 0 && UUT.chk.fail_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout, the run did not complete by %0t", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: compile.f
logic/core_pkg.sv
logic/imem_pkg.sv
logic/inst_mem.sv
logic/fetch_stage.sv
logic/fetch_queue.sv
logic/fetch_top.sv
sim/clock_gen.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
